// File: source/vec_pkg.sv
package vec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] vreg_t;
    typedef logic [4:0]  vreg_addr_t;
    typedef logic [7:0]  byte_en_t;
    typedef logic [2:0]  sew_t;
    typedef logic [3:0]  vl_t;
    typedef logic [15:0] mem_addr_t;
    typedef logic [5:0]  funct6_t;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_WAIT_ALU,
        DEC_WAIT_LSU,
        DEC_RESPOND
    } dec_state_t;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_LOAD_WAIT,
        LSU_DONE
    } lsu_state_t;

    // Major opcodes
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
    localparam logic [6:0] OPC_OP_V     = 7'b1010111;

    // OP-V funct3 categories
    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [2:0] F3_OPIVI = 3'b011;
    localparam logic [2:0] F3_OPIVX = 3'b100;
    localparam logic [2:0] F3_OPCFG = 3'b111;

    localparam funct6_t F6_VADD = 6'b000000;
    localparam funct6_t F6_VSUB = 6'b000010;
    localparam funct6_t F6_VAND = 6'b001001;
    localparam funct6_t F6_VOR  = 6'b001010;
    localparam funct6_t F6_VXOR = 6'b001011;

    localparam int NUM_VREGS  = 32;
    localparam int VLEN_BYTES = 8;

endpackage

// File: source/vec_decoder.sv
`timescale 1ns/1ns

module vec_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  vec_pkg::word_t      insn,
    input  vec_pkg::word_t      rs1,
    input  vec_pkg::vreg_t      v0,
    input  logic                alu_done,
    input  logic                lsu_done,
    output logic                req_ready,
    output logic                resp_valid,
    output vec_pkg::word_t      resp_data,
    output logic                resp_err,
    output vec_pkg::vreg_addr_t vs1,
    output vec_pkg::vreg_addr_t vs2,
    output vec_pkg::vreg_addr_t rd_addr_b,
    output vec_pkg::vreg_addr_t vd,
    output vec_pkg::sew_t       vsew,
    output logic                use_scalar,
    output vec_pkg::word_t      scalar,
    output vec_pkg::funct6_t    funct6,
    output vec_pkg::mem_addr_t  mem_addr,
    output logic                is_store,
    output vec_pkg::byte_en_t   byte_en,
    output logic                sel_vld_res,
    output logic                alu_start,
    output logic                lsu_start
);

    vec_pkg::dec_state_t state;
    vec_pkg::vl_t        vl;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                accept;
    logic                cfg_ok;
    logic                arith_ok;
    logic                mem_ok;
    vec_pkg::word_t      avl;
    vec_pkg::vl_t        vlmax;
    vec_pkg::vl_t        new_vl;
    vec_pkg::byte_en_t   act_be;
    logic [2:0]          elem;

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];

    // Ready again in the response cycle
    assign req_ready  = (state == vec_pkg::DEC_IDLE) || (state == vec_pkg::DEC_RESPOND);
    assign resp_valid = (state == vec_pkg::DEC_RESPOND);
    assign accept     = req_valid && req_ready;

    // vsetvl form and element widths above 64 bits are rejected
    assign cfg_ok = (opcode == vec_pkg::OPC_OP_V) && (funct3 == vec_pkg::F3_OPCFG)
                    && (insn[31:30] != 2'b10) && !insn[25];

    assign arith_ok = (opcode == vec_pkg::OPC_OP_V)
                      && (funct3 inside {vec_pkg::F3_OPIVV, vec_pkg::F3_OPIVI,
                                         vec_pkg::F3_OPIVX})
                      && (insn[31:26] inside {vec_pkg::F6_VADD, vec_pkg::F6_VSUB,
                                              vec_pkg::F6_VAND, vec_pkg::F6_VOR,
                                              vec_pkg::F6_VXOR});

    assign mem_ok = (opcode == vec_pkg::OPC_LOAD_FP) || (opcode == vec_pkg::OPC_STORE_FP);

    // Requested length, clamped to 8 bytes per register
    assign avl    = insn[31] ? {27'd0, insn[19:15]} : rs1;
    assign vlmax  = 4'd8 >> insn[24:23];
    assign new_vl = (avl > {28'd0, vlmax}) ? vlmax : avl[3:0];

    // Bytes of active elements under the current vl, vsew and mask
    always_comb
    begin
        act_be = '0;
        elem   = '0;
        for (int b = 0; b < vec_pkg::VLEN_BYTES; b++)
        begin
            elem      = 3'(b >> vsew[1:0]);
            act_be[b] = ({1'b0, elem} < vl) && (insn[25] || v0[elem]);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= vec_pkg::DEC_IDLE;
            vl        <= '0;
            vsew      <= '0;
            resp_data <= '0;
            resp_err  <= 1'b0;
            alu_start <= 1'b0;
            lsu_start <= 1'b0;
        end
        else
        begin
            alu_start <= 1'b0;
            lsu_start <= 1'b0;
            case (state)
                vec_pkg::DEC_WAIT_ALU:
                begin
                    if (alu_done)
                    begin
                        state <= vec_pkg::DEC_RESPOND;
                    end
                end
                vec_pkg::DEC_WAIT_LSU:
                begin
                    if (lsu_done)
                    begin
                        state <= vec_pkg::DEC_RESPOND;
                    end
                end
                default:
                begin
                    state <= vec_pkg::DEC_IDLE;
                    if (accept)
                    begin
                        resp_data <= '0;
                        resp_err  <= 1'b0;
                        if (cfg_ok)
                        begin
                            vl        <= new_vl;
                            vsew      <= insn[25:23];
                            resp_data <= {28'd0, new_vl};
                            state     <= vec_pkg::DEC_RESPOND;
                        end
                        else if (arith_ok)
                        begin
                            alu_start <= 1'b1;
                            state     <= vec_pkg::DEC_WAIT_ALU;
                        end
                        else if (mem_ok)
                        begin
                            lsu_start <= 1'b1;
                            state     <= vec_pkg::DEC_WAIT_LSU;
                        end
                        else
                        begin
                            resp_err <= 1'b1;
                            state    <= vec_pkg::DEC_RESPOND;
                        end
                    end
                end
            endcase
        end
    end

    // Fields held for the units while the instruction runs
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            vs1         <= insn[19:15];
            vs2         <= insn[24:20];
            vd          <= insn[11:7];
            funct6      <= insn[31:26];
            use_scalar  <= (funct3 != vec_pkg::F3_OPIVV);
            scalar      <= (funct3 == vec_pkg::F3_OPIVI) ? {{27{insn[19]}}, insn[19:15]} : rs1;
            mem_addr    <= rs1[15:0];
            is_store    <= (opcode == vec_pkg::OPC_STORE_FP);
            sel_vld_res <= (opcode == vec_pkg::OPC_LOAD_FP);
            byte_en     <= act_be;
        end
    end

    // Store data comes from vd (vs3)
    assign rd_addr_b = is_store ? vd : vs1;

endmodule

// File: source/vec_regfile.sv
`timescale 1ns/1ns

module vec_regfile (
    input  logic                clk,
    input  logic                rst,
    input  vec_pkg::vreg_addr_t rd_addr_a,
    input  vec_pkg::vreg_addr_t rd_addr_b,
    input  vec_pkg::vreg_addr_t wr_addr,
    input  vec_pkg::byte_en_t   byte_en,
    input  logic                sel_vld_res,
    input  logic                alu_wr_en,
    input  vec_pkg::vreg_t      alu_wr_data,
    input  logic                lsu_wr_en,
    input  vec_pkg::vreg_t      lsu_wr_data,
    output vec_pkg::vreg_t      rd_data_a,
    output vec_pkg::vreg_t      rd_data_b,
    output vec_pkg::vreg_t      v0
);

    vec_pkg::vreg_t regs [vec_pkg::NUM_VREGS];
    vec_pkg::vreg_t wr_data;
    logic           wr_en;

    // Load result or ALU result
    assign wr_en   = sel_vld_res ? lsu_wr_en : alu_wr_en;
    assign wr_data = sel_vld_res ? lsu_wr_data : alu_wr_data;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int r = 0; r < vec_pkg::NUM_VREGS; r++)
            begin
                regs[r] <= '0;
            end
        end
        else if (wr_en)
        begin
            for (int b = 0; b < vec_pkg::VLEN_BYTES; b++)
            begin
                if (byte_en[b])
                begin
                    regs[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    assign v0        = regs[0];

endmodule

// File: source/vec_alu.sv
`timescale 1ns/1ns

module vec_alu (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  vec_pkg::funct6_t funct6,
    input  vec_pkg::sew_t    vsew,
    input  logic             use_scalar,
    input  vec_pkg::word_t   scalar,
    input  vec_pkg::vreg_t   src_a,
    input  vec_pkg::vreg_t   src_b,
    output logic             wr_en,
    output vec_pkg::vreg_t   wr_data,
    output logic             done
);

    vec_pkg::vreg_t scalar_rep;
    vec_pkg::vreg_t operand_b;
    vec_pkg::vreg_t add_b;
    vec_pkg::vreg_t sum;
    vec_pkg::vreg_t result;
    logic           is_sub;
    logic           carry;
    logic [8:0]     byte_sum;
    logic [3:0]     elem_bytes;

    // Scalar cut or sign-extended to one element, copied to every lane
    always_comb
    begin
        case (vsew)
            3'd0:    scalar_rep = {8{scalar[7:0]}};
            3'd1:    scalar_rep = {4{scalar[15:0]}};
            3'd2:    scalar_rep = {2{scalar}};
            default: scalar_rep = {{32{scalar[31]}}, scalar};
        endcase
    end

    assign operand_b  = use_scalar ? scalar_rep : src_b;
    assign is_sub     = (funct6 == vec_pkg::F6_VSUB);
    assign add_b      = is_sub ? ~operand_b : operand_b;
    assign elem_bytes = 4'd1 << vsew[1:0];

    // Byte-wise adder, carry chain restarts at each element
    always_comb
    begin
        sum      = '0;
        carry    = 1'b0;
        byte_sum = '0;
        for (int i = 0; i < vec_pkg::VLEN_BYTES; i++)
        begin
            if ((4'(i) & (elem_bytes - 4'd1)) == 4'd0)
            begin
                carry = is_sub;
            end
            byte_sum      = {1'b0, src_a[8*i +: 8]} + {1'b0, add_b[8*i +: 8]} + {8'd0, carry};
            sum[8*i +: 8] = byte_sum[7:0];
            carry         = byte_sum[8];
        end
    end

    always_comb
    begin
        case (funct6)
            vec_pkg::F6_VADD: result = sum;
            vec_pkg::F6_VSUB: result = sum;
            vec_pkg::F6_VAND: result = src_a & operand_b;
            vec_pkg::F6_VOR:  result = src_a | operand_b;
            vec_pkg::F6_VXOR: result = src_a ^ operand_b;
            default:          result = src_a;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_en <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            wr_en <= start;
            done  <= start;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            wr_data <= result;
        end
    end

endmodule

// File: source/vec_lsu.sv
`timescale 1ns/1ns

module vec_lsu (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               is_store,
    input  vec_pkg::mem_addr_t addr,
    input  vec_pkg::vreg_t     store_data,
    input  vec_pkg::byte_en_t  byte_en,
    input  vec_pkg::vreg_t     mem_rdata,
    output logic               mem_req,
    output logic               mem_we,
    output vec_pkg::mem_addr_t mem_addr,
    output vec_pkg::vreg_t     mem_wdata,
    output vec_pkg::byte_en_t  mem_be,
    output logic               wr_en,
    output vec_pkg::vreg_t     wr_data,
    output logic               done
);

    vec_pkg::lsu_state_t state;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= vec_pkg::LSU_IDLE;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            wr_en   <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            wr_en <= 1'b0;
            done  <= 1'b0;
            case (state)
                vec_pkg::LSU_IDLE:
                begin
                    if (start)
                    begin
                        mem_req <= 1'b1;
                        mem_we  <= is_store;
                        state   <= is_store ? vec_pkg::LSU_DONE : vec_pkg::LSU_LOAD_WAIT;
                    end
                end
                vec_pkg::LSU_LOAD_WAIT:
                begin
                    // Read data shows up next cycle
                    mem_req <= 1'b0;
                    state   <= vec_pkg::LSU_DONE;
                end
                vec_pkg::LSU_DONE:
                begin
                    mem_req <= 1'b0;
                    mem_we  <= 1'b0;
                    wr_en   <= !mem_we;
                    done    <= 1'b1;
                    state   <= vec_pkg::LSU_IDLE;
                end
                default:
                begin
                    state <= vec_pkg::LSU_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == vec_pkg::LSU_IDLE) && start)
        begin
            mem_addr  <= addr;
            mem_wdata <= store_data;
            mem_be    <= byte_en;
        end
        if (state == vec_pkg::LSU_DONE)
        begin
            wr_data <= mem_rdata;
        end
    end

endmodule

// File: source/vec_unit_top.sv
`timescale 1ns/1ns

module vec_unit_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  vec_pkg::word_t     insn,
    input  vec_pkg::word_t     rs1,
    input  vec_pkg::vreg_t     mem_rdata,
    output logic               req_ready,
    output logic               resp_valid,
    output vec_pkg::word_t     resp_data,
    output logic               resp_err,
    output logic               mem_req,
    output logic               mem_we,
    output vec_pkg::mem_addr_t mem_addr,
    output vec_pkg::vreg_t     mem_wdata,
    output vec_pkg::byte_en_t  mem_be
);

    vec_pkg::vreg_t      v0;
    vec_pkg::vreg_addr_t vs2;
    vec_pkg::vreg_addr_t rd_addr_b;
    vec_pkg::vreg_addr_t vd;
    vec_pkg::sew_t       vsew;
    logic                use_scalar;
    vec_pkg::word_t      scalar;
    vec_pkg::funct6_t    funct6;
    vec_pkg::mem_addr_t  lsu_addr;
    logic                is_store;
    vec_pkg::byte_en_t   byte_en;
    logic                sel_vld_res;
    logic                alu_start;
    logic                lsu_start;
    logic                alu_done;
    logic                lsu_done;
    logic                alu_wr_en;
    logic                lsu_wr_en;
    vec_pkg::vreg_t      alu_wr_data;
    vec_pkg::vreg_t      lsu_wr_data;
    vec_pkg::vreg_t      rd_data_a;
    vec_pkg::vreg_t      rd_data_b;

    // vs1 only reaches the register file through rd_addr_b
    vec_decoder vec_decoder_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .insn        (insn),
        .rs1         (rs1),
        .v0          (v0),
        .alu_done    (alu_done),
        .lsu_done    (lsu_done),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_err    (resp_err),
        .vs1         (),
        .vs2         (vs2),
        .rd_addr_b   (rd_addr_b),
        .vd          (vd),
        .vsew        (vsew),
        .use_scalar  (use_scalar),
        .scalar      (scalar),
        .funct6      (funct6),
        .mem_addr    (lsu_addr),
        .is_store    (is_store),
        .byte_en     (byte_en),
        .sel_vld_res (sel_vld_res),
        .alu_start   (alu_start),
        .lsu_start   (lsu_start)
    );

    vec_regfile vec_regfile_i (
        .clk         (clk),
        .rst         (rst),
        .rd_addr_a   (vs2),
        .rd_addr_b   (rd_addr_b),
        .wr_addr     (vd),
        .byte_en     (byte_en),
        .sel_vld_res (sel_vld_res),
        .alu_wr_en   (alu_wr_en),
        .alu_wr_data (alu_wr_data),
        .lsu_wr_en   (lsu_wr_en),
        .lsu_wr_data (lsu_wr_data),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .v0          (v0)
    );

    vec_alu vec_alu_i (
        .clk        (clk),
        .rst        (rst),
        .start      (alu_start),
        .funct6     (funct6),
        .vsew       (vsew),
        .use_scalar (use_scalar),
        .scalar     (scalar),
        .src_a      (rd_data_a),
        .src_b      (rd_data_b),
        .wr_en      (alu_wr_en),
        .wr_data    (alu_wr_data),
        .done       (alu_done)
    );

    vec_lsu vec_lsu_i (
        .clk        (clk),
        .rst        (rst),
        .start      (lsu_start),
        .is_store   (is_store),
        .addr       (lsu_addr),
        .store_data (rd_data_b),
        .byte_en    (byte_en),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_be     (mem_be),
        .wr_en      (lsu_wr_en),
        .wr_data    (lsu_wr_data),
        .done       (lsu_done)
    );

endmodule

// File: tests/vec_unit_tb.sv
`timescale 1ns/1ns

module vec_unit_tb;

    localparam int N_CFG  = 24;
    localparam int N_VV   = 40;
    localparam int N_VX   = 40;
    localparam int N_MASK = 48;
    localparam int N_ILL  = 10;
    localparam int NUM_INSNS = N_CFG + 3 + 33 + 4 * (N_VV + N_VX + N_MASK) + 3 * N_ILL;
    localparam int CYCLE_LIMIT = NUM_INSNS * 8 + 200;

    logic                clk;
    logic                rst;
    logic                req_valid;
    vec_pkg::word_t      insn;
    vec_pkg::word_t      rs1;
    vec_pkg::vreg_t      mem_rdata;
    logic                req_ready;
    logic                resp_valid;
    vec_pkg::word_t      resp_data;
    logic                resp_err;
    logic                mem_req;
    logic                mem_we;
    vec_pkg::mem_addr_t  mem_addr;
    vec_pkg::vreg_t      mem_wdata;
    vec_pkg::byte_en_t   mem_be;

    // Behavioural memory and reference state
    vec_pkg::vreg_t      mem [65536];
    vec_pkg::byte_en_t   last_be;
    vec_pkg::vreg_t      model_mem [vec_pkg::mem_addr_t];
    vec_pkg::vreg_t      mregs [vec_pkg::NUM_VREGS];
    vec_pkg::vl_t        mvl;
    vec_pkg::sew_t       msew;

    logic [31:0]         lfsr;
    int                  cycles;
    int                  n_checks;
    int                  n_errors;

    vec_unit_top vec_unit_top_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .insn       (insn),
        .rs1        (rs1),
        .mem_rdata  (mem_rdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_err   (resp_err),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_be     (mem_be)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // One-cycle read, byte-masked write
    always @(posedge clk)
    begin
        if (mem_req && !mem_we)
        begin
            mem_rdata <= mem[mem_addr];
        end
        if (mem_req && mem_we)
        begin
            mem[mem_addr] <= merge(mem[mem_addr], mem_wdata, mem_be);
            last_be       <= mem_be;
        end
    end

    function automatic vec_pkg::vreg_t fill_word(input vec_pkg::mem_addr_t a);
        return {a ^ 16'h3c5a, a, ~a, a * 16'd37};
    endfunction

    function automatic vec_pkg::vreg_t merge(input vec_pkg::vreg_t old_w,
                                             input vec_pkg::vreg_t new_w,
                                             input vec_pkg::byte_en_t be);
        vec_pkg::vreg_t r;
        r = old_w;
        for (int b = 0; b < 8; b++)
        begin
            if (be[b])
            begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic vec_pkg::vreg_t model_read(input vec_pkg::mem_addr_t a);
        if (model_mem.exists(a))
        begin
            return model_mem[a];
        end
        return fill_word(a);
    endfunction

    // Bytes of elements below vl and, when masked, enabled in v0
    function automatic vec_pkg::byte_en_t active_be(input logic vm);
        vec_pkg::byte_en_t be;
        int                e;
        be = '0;
        for (int b = 0; b < 8; b++)
        begin
            e     = b / (1 << msew);
            be[b] = (e < mvl) && (vm || mregs[0][e]);
        end
        return be;
    endfunction

    function automatic vec_pkg::vreg_t model_alu(input vec_pkg::funct6_t f6,
                                                 input vec_pkg::vreg_t a,
                                                 input vec_pkg::vreg_t b,
                                                 input logic use_s,
                                                 input vec_pkg::word_t s);
        int          ew;
        logic [63:0] m;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] r;
        logic [63:0] res;
        ew  = 8 << msew;
        m   = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        res = '0;
        for (int e = 0; e < 8 / (1 << msew); e++)
        begin
            ea = (a >> (e * ew)) & m;
            if (!use_s)
            begin
                eb = (b >> (e * ew)) & m;
            end
            else if (msew == 3)
            begin
                eb = {{32{s[31]}}, s};
            end
            else
            begin
                eb = {32'd0, s} & m;
            end
            case (f6)
                vec_pkg::F6_VADD: r = (ea + eb) & m;
                vec_pkg::F6_VSUB: r = (ea - eb) & m;
                vec_pkg::F6_VAND: r = ea & eb;
                vec_pkg::F6_VOR:  r = ea | eb;
                default:          r = ea ^ eb;
            endcase
            res = res | (r << (e * ew));
        end
        return res;
    endfunction

    function automatic vec_pkg::funct6_t pick_f6();
        case (rand_bits(3) % 5)
            0:       return vec_pkg::F6_VADD;
            1:       return vec_pkg::F6_VSUB;
            2:       return vec_pkg::F6_VAND;
            3:       return vec_pkg::F6_VOR;
            default: return vec_pkg::F6_VXOR;
        endcase
    endfunction

    task automatic check_word(input vec_pkg::word_t got, input vec_pkg::word_t exp,
                              input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_vreg(input vec_pkg::vreg_t got, input vec_pkg::vreg_t exp,
                              input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_be(input vec_pkg::byte_en_t got, input vec_pkg::byte_en_t exp,
                            input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Send one instruction and check latency, error flag and data
    task automatic run(input vec_pkg::word_t ins, input vec_pkg::word_t r1, input int exp_lat,
                       input logic exp_err, input vec_pkg::word_t exp_data);
        int lat;
        req_valid <= 1'b1;
        insn      <= ins;
        rs1       <= r1;
        @(posedge clk);
        while (!req_ready)
        begin
            @(posedge clk);
        end
        req_valid <= 1'b0;
        lat = 0;
        do
        begin
            @(posedge clk);
            lat++;
        end
        while (!resp_valid);
        check_word(vec_pkg::word_t'(lat), vec_pkg::word_t'(exp_lat), "latency");
        check_bit(resp_err, exp_err, "resp_err");
        check_word(resp_data, exp_data, "resp_data");
    endtask

    task automatic do_cfg(input logic imm_form, input logic [2:0] sew, input vec_pkg::word_t avl);
        vec_pkg::word_t ins;
        vec_pkg::word_t vlmax;
        vec_pkg::word_t exp_vl;
        if (imm_form)
        begin
            ins = {2'b11, 4'd0, sew, 3'd0, avl[4:0], vec_pkg::F3_OPCFG, 5'd1, vec_pkg::OPC_OP_V};
        end
        else
        begin
            ins = {1'b0, 5'd0, sew, 3'd0, 5'd2, vec_pkg::F3_OPCFG, 5'd1, vec_pkg::OPC_OP_V};
        end
        vlmax  = 8 >> sew[1:0];
        exp_vl = imm_form ? {27'd0, avl[4:0]} : avl;
        if (exp_vl > vlmax)
        begin
            exp_vl = vlmax;
        end
        run(ins, avl, 1, 1'b0, exp_vl);
        mvl  = exp_vl[3:0];
        msew = sew;
    endtask

    task automatic do_arith(input vec_pkg::funct6_t f6, input logic [2:0] f3, input logic vm,
                            input vec_pkg::vreg_addr_t vd, input vec_pkg::vreg_addr_t vs2,
                            input logic [4:0] f1, input vec_pkg::word_t r1);
        vec_pkg::word_t    s;
        vec_pkg::byte_en_t be;
        vec_pkg::vreg_t    res;
        s   = (f3 == vec_pkg::F3_OPIVI) ? {{27{f1[4]}}, f1} : r1;
        be  = active_be(vm);
        res = model_alu(f6, mregs[vs2], mregs[f1], f3 != vec_pkg::F3_OPIVV, s);
        run({f6, vm, vs2, f1, f3, vd, vec_pkg::OPC_OP_V}, r1, 3, 1'b0, '0);
        mregs[vd] = merge(mregs[vd], res, be);
    endtask

    task automatic do_load(input logic vm, input vec_pkg::vreg_addr_t vd,
                           input vec_pkg::mem_addr_t a);
        vec_pkg::byte_en_t be;
        be = active_be(vm);
        run({6'd0, vm, 5'd0, 5'd3, 3'b111, vd, vec_pkg::OPC_LOAD_FP}, {16'd0, a}, 5, 1'b0, '0);
        mregs[vd] = merge(mregs[vd], model_read(a), be);
    endtask

    task automatic do_store(input logic vm, input vec_pkg::vreg_addr_t vs3,
                            input vec_pkg::mem_addr_t a);
        vec_pkg::byte_en_t be;
        be = active_be(vm);
        run({6'd0, vm, 5'd0, 5'd3, 3'b111, vs3, vec_pkg::OPC_STORE_FP}, {16'd0, a}, 4, 1'b0, '0);
        model_mem[a] = merge(model_read(a), mregs[vs3], be);
        check_be(last_be, be, "mem_be");
        check_vreg(mem[a], model_mem[a], "memory word");
    endtask

    // Full-length store of one register to a random address
    task automatic store_check(input vec_pkg::vreg_addr_t r);
        do_cfg(1'b1, 3'd0, 32'd8);
        do_store(1'b1, r, vec_pkg::mem_addr_t'(rand_bits(16)));
    endtask

    task automatic poke(input vec_pkg::mem_addr_t a, input vec_pkg::vreg_t w);
        mem[a]       = w;
        model_mem[a] = w;
    endtask

    task automatic report(input string name, input int errs_before);
        $display("%s: %s", name, (n_errors == errs_before) ? "passed" : "FAILED");
    endtask

    task automatic random_arith(input logic vm, input vec_pkg::vreg_addr_t vd);
        logic [2:0] f3;
        case (rand_bits(2) % 3)
            0:       f3 = vec_pkg::F3_OPIVV;
            1:       f3 = vec_pkg::F3_OPIVX;
            default: f3 = vec_pkg::F3_OPIVI;
        endcase
        do_arith(pick_f6(), f3, vm, vd, rand_bits(5), rand_bits(5), rand_bits(32));
    endtask

    initial
    begin
        vec_pkg::vreg_addr_t r;
        vec_pkg::mem_addr_t  a;
        vec_pkg::vreg_t      w;
        vec_pkg::word_t      bad_insn;
        int                  errs;
        int                  kind;
        logic [2:0]          f3;
        lfsr      = 32'hb778;
        cycles    = 0;
        n_checks  = 0;
        n_errors  = 0;
        rst       = 1'b1;
        req_valid = 1'b0;
        insn      = '0;
        rs1       = '0;
        mem_rdata = '0;
        last_be   = '0;
        mvl       = '0;
        msew      = '0;
        for (int i = 0; i < 65536; i++)
        begin
            mem[i] = fill_word(vec_pkg::mem_addr_t'(i));
        end
        for (int i = 0; i < vec_pkg::NUM_VREGS; i++)
        begin
            mregs[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        errs = n_errors;
        check_bit(req_ready, 1'b1, "req_ready after reset");
        for (int i = 0; i < N_CFG; i++)
        begin
            do_cfg(rand_bits(1), rand_bits(2), rand_bits(1) ? rand_bits(32) : rand_bits(4));
        end
        report("test 1 vsetvli/vsetivli", errs);

        errs = n_errors;
        do_cfg(1'b1, 3'd0, 32'd8);
        r = rand_bits(5);
        a = rand_bits(16);
        w = rand_bits(64);
        poke(a, w);
        do_load(1'b1, r, a);
        do_store(1'b1, r, a + 16'd1);
        check_vreg(mem[a + 16'd1], w, "copied word");
        report("test 2 load and store", errs);

        // Random contents in every register
        do_cfg(1'b1, 3'd0, 32'd8);
        for (int i = 0; i < vec_pkg::NUM_VREGS; i++)
        begin
            a = rand_bits(16);
            poke(a, rand_bits(64));
            do_load(1'b1, i[4:0], a);
        end

        errs = n_errors;
        for (int i = 0; i < N_VV; i++)
        begin
            do_cfg(rand_bits(1), rand_bits(2), rand_bits(4));
            r = rand_bits(5);
            do_arith(pick_f6(), vec_pkg::F3_OPIVV, 1'b1, r, rand_bits(5), rand_bits(5), '0);
            store_check(r);
        end
        report("test 3 vector-vector", errs);

        errs = n_errors;
        for (int i = 0; i < N_VX; i++)
        begin
            do_cfg(rand_bits(1), rand_bits(2), rand_bits(4));
            r  = rand_bits(5);
            f3 = rand_bits(1) ? vec_pkg::F3_OPIVX : vec_pkg::F3_OPIVI;
            do_arith(pick_f6(), f3, 1'b1, r, rand_bits(5), rand_bits(5), rand_bits(32));
            store_check(r);
        end
        report("test 4 vector-scalar and immediate", errs);

        errs = n_errors;
        for (int i = 0; i < N_MASK; i++)
        begin
            do_cfg(rand_bits(1), rand_bits(2), rand_bits(4));
            kind = rand_bits(2);
            r    = rand_bits(5);
            if (kind < 2)
            begin
                random_arith(1'b0, r);
                store_check(r);
            end
            else if (kind == 2)
            begin
                do_load(1'b0, r, rand_bits(16));
                store_check(r);
            end
            else
            begin
                do_store(1'b0, r, rand_bits(16));
            end
        end
        report("test 5 masked operations", errs);

        errs = n_errors;
        for (int i = 0; i < N_ILL; i++)
        begin
            r = rand_bits(5);
            case (i % 5)
                0:       bad_insn = {20'h000ab, r, 7'b0110011};
                1:       bad_insn = {vec_pkg::F6_VADD, 1'b1, 10'h155, 3'b010, r,
                                     vec_pkg::OPC_OP_V};
                2:       bad_insn = {6'b100101, 1'b1, 10'h0c3, vec_pkg::F3_OPIVV, r,
                                     vec_pkg::OPC_OP_V};
                3:       bad_insn = {1'b1, 6'd0, 10'h062, vec_pkg::F3_OPCFG, r,
                                     vec_pkg::OPC_OP_V};
                default: bad_insn = {6'd0, 3'b100 | 3'(rand_bits(2)), 3'd0, 5'd4,
                                     vec_pkg::F3_OPCFG, r, vec_pkg::OPC_OP_V};
            endcase
            run(bad_insn, rand_bits(32), 1, 1'b1, '0);
            store_check(r);
        end
        report("test 6 illegal instructions", errs);

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
source/vec_pkg.sv
source/vec_decoder.sv
source/vec_regfile.sv
source/vec_alu.sv
source/vec_lsu.sv
source/vec_unit_top.sv
tests/vec_unit_tb.sv
